// ==== project.f ====
useless_box_pkg.sv
ir_debounce.sv
box_mode_ctrl.sv
servo_planner.sv
motor_planner.sv
useless_box_top.sv
tb_clock_gen.sv
tb_useless_box.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_useless_box
FILELIST   := project.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_useless_box.sv ====
/*
 * Table-driven testbench for useless_box_top, DEBOUNCE_LEN set to 4.
 * Inputs change on falling edges, outputs are sampled on falling edges.
 * The table assumes GOOD_DIS 20 and SIDE_DELTA 4.
 */
`timescale 1ns/1ps

module tb_useless_box
  import useless_box_pkg::*;
();

  localparam int DEBOUNCE_LEN = 4;
  localparam int NUM_TESTS    = 26;
  // Reset plus per row presses, pulse, settle wait and check with slack
  localparam int MAX_CYCLES   = 16 + NUM_TESTS * (3 + DEBOUNCE_LEN + 3 + 2) + 64;

  logic                   clk;
  logic                   rst;
  logic                   mode_press;
  logic                   ble_switch;
  logic                   sw0;
  logic [2:0]             wanted_ub;
  logic [NUM_IR-1:0]      ir_sensor;
  logic [DIST_W-1:0]      distance_0;
  logic [DIST_W-1:0]      distance_1;
  logic                   ble_forward;
  logic                   ble_backward;
  logic                   ble_left;
  logic                   ble_right;
  logic                   ble_err;
  logic [1:0]             mode;
  logic                   relay;
  logic                   servo_enable;
  logic                   servo_sel;
  logic [SERVO_AMT_W-1:0] servo_amount;
  logic [1:0]             motor_cw;
  logic [1:0]             motor_ccw;

  // Stimulus columns
  string             t_name  [NUM_TESTS];
  logic [1:0]        t_mode  [NUM_TESTS];
  logic              t_sw0   [NUM_TESTS];
  logic [2:0]        t_wub   [NUM_TESTS];
  logic [NUM_IR-1:0] t_ir    [NUM_TESTS];
  logic [DIST_W-1:0] t_d0    [NUM_TESTS];
  logic [DIST_W-1:0] t_d1    [NUM_TESTS];
  logic [4:0]        t_cmd   [NUM_TESTS];
  logic              t_pulse [NUM_TESTS];
  // Expected columns
  logic [1:0]        e_mode  [NUM_TESTS];
  logic              e_relay [NUM_TESTS];
  logic              e_en    [NUM_TESTS];
  logic              e_sel   [NUM_TESTS];
  logic [4:0]        e_amt   [NUM_TESTS];
  logic [1:0]        e_cw    [NUM_TESTS];
  logic [1:0]        e_ccw   [NUM_TESTS];

  int         rows_filled = 0;
  int         row_errors  = 0;
  int         pass_count  = 0;
  int         fail_count  = 0;
  int         cycle_count = 0;
  logic [1:0] pred_mode;

  tb_clock_gen #(
    .PERIOD_NS    (100),
    .RESET_CYCLES (16)
  ) u_tb_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  useless_box_top #(
    .DEBOUNCE_LEN (DEBOUNCE_LEN)
  ) u_useless_box_top (
    .clk          (clk),
    .rst          (rst),
    .mode_press   (mode_press),
    .ble_switch   (ble_switch),
    .sw0          (sw0),
    .wanted_ub    (wanted_ub),
    .ir_sensor    (ir_sensor),
    .distance_0   (distance_0),
    .distance_1   (distance_1),
    .ble_forward  (ble_forward),
    .ble_backward (ble_backward),
    .ble_left     (ble_left),
    .ble_right    (ble_right),
    .ble_err      (ble_err),
    .mode         (mode),
    .relay        (relay),
    .servo_enable (servo_enable),
    .servo_sel    (servo_sel),
    .servo_amount (servo_amount),
    .motor_cw     (motor_cw),
    .motor_ccw    (motor_ccw)
  );

  // Button rotation NS -> UB -> UC -> NS
  function automatic logic [1:0] rotate_mode(input logic [1:0] m);
    case (m)
      MODE_NS: return MODE_UB;
      MODE_UB: return MODE_UC;
      default: return MODE_NS;
    endcase
  endfunction

  // cmd bits are {forward, backward, left, right, err}
  task automatic add_test(input string name, input logic [1:0] m, input logic s,
                          input logic [2:0] wub, input logic [3:0] ir, input int d0,
                          input int d1, input logic [4:0] cmd, input logic pulse,
                          input logic [1:0] x_mode, input logic x_relay, input logic x_en,
                          input logic x_sel, input int x_amt, input logic [1:0] x_cw,
                          input logic [1:0] x_ccw);
    t_name[rows_filled]  = name;
    t_mode[rows_filled]  = m;
    t_sw0[rows_filled]   = s;
    t_wub[rows_filled]   = wub;
    t_ir[rows_filled]    = ir;
    t_d0[rows_filled]    = DIST_W'(d0);
    t_d1[rows_filled]    = DIST_W'(d1);
    t_cmd[rows_filled]   = cmd;
    t_pulse[rows_filled] = pulse;
    e_mode[rows_filled]  = x_mode;
    e_relay[rows_filled] = x_relay;
    e_en[rows_filled]    = x_en;
    e_sel[rows_filled]   = x_sel;
    e_amt[rows_filled]   = 5'(x_amt);
    e_cw[rows_filled]    = x_cw;
    e_ccw[rows_filled]   = x_ccw;
    rows_filled++;
  endtask

  // The wanted position starts equal to sw0, which is 0 after reset
  // Dodge stops below 7 or with both above 10 and distance 1 gets +4
  task automatic fill_table();
    add_test("reset_state", MODE_NS, 0, 3'b001, 4'hF, 100, 100, 5'b00000, 0,
             MODE_NS, 0, 0, 0, 0, 2'b00, 2'b00);
    add_test("ble_switch_align", MODE_NS, 1, 3'b001, 4'hF, 100, 100, 5'b00000, 1,
             MODE_NS, 1, 0, 1, 0, 2'b00, 2'b00);
    add_test("ble_switch_err", MODE_NS, 1, 3'b001, 4'hF, 100, 100, 5'b00001, 1,
             MODE_NS, 1, 0, 1, 0, 2'b00, 2'b00);
    add_test("ble_switch_push", MODE_NS, 1, 3'b001, 4'hF, 100, 100, 5'b00000, 1,
             MODE_NS, 1, 1, 0, 31, 2'b00, 2'b00);
    add_test("ns_on_target", MODE_NS, 0, 3'b001, 4'hF, 100, 100, 5'b00000, 0,
             MODE_NS, 0, 0, 0, 0, 2'b00, 2'b00);
    // Advance style keeps the arm on the far side of sw0
    add_test("adv_far", MODE_UB, 0, 3'b100, 4'hF, 100, 100, 5'b00000, 0,
             MODE_UB, 0, 1, 1, 0, 2'b00, 2'b00);
    add_test("adv_near", MODE_UB, 0, 3'b100, 4'hF, 5, 10, 5'b00000, 0,
             MODE_UB, 0, 1, 1, 15, 2'b00, 2'b00);
    add_test("adv_cap", MODE_UB, 0, 3'b100, 4'hF, 12, 30, 5'b00000, 0,
             MODE_UB, 0, 1, 1, 31, 2'b00, 2'b00);
    add_test("adv_side_delta", MODE_UB, 0, 3'b100, 4'hF, 40, 2, 5'b00000, 0,
             MODE_UB, 0, 1, 1, 18, 2'b00, 2'b00);
    add_test("adv_ir_near", MODE_UB, 0, 3'b100, 4'b1101, 100, 100, 5'b00000, 0,
             MODE_UB, 0, 1, 1, 31, 2'b00, 2'b00);
    add_test("classic_push", MODE_UB, 1, 3'b001, 4'hF, 100, 100, 5'b00000, 0,
             MODE_UB, 0, 1, 0, 31, 2'b00, 2'b00);
    add_test("classic_idle", MODE_UB, 0, 3'b001, 4'hF, 100, 100, 5'b00000, 0,
             MODE_UB, 0, 1, 0, 0, 2'b00, 2'b00);
    add_test("ub_ble_ignored", MODE_UB, 0, 3'b001, 4'hF, 100, 100, 5'b00000, 1,
             MODE_UB, 0, 1, 0, 0, 2'b00, 2'b00);
    add_test("dodge_reverse", MODE_UB, 0, 3'b010, 4'hF, 9, 4, 5'b00000, 0,
             MODE_UB, 0, 1, 0, 0, 2'b00, 2'b11);
    add_test("dodge_forward", MODE_UB, 0, 3'b010, 4'hF, 8, 5, 5'b00000, 0,
             MODE_UB, 0, 1, 0, 0, 2'b11, 2'b00);
    add_test("dodge_too_close", MODE_UB, 0, 3'b010, 4'hF, 3, 20, 5'b00000, 0,
             MODE_UB, 0, 1, 0, 0, 2'b00, 2'b00);
    add_test("dodge_too_far", MODE_UB, 0, 3'b010, 4'hF, 11, 7, 5'b00000, 0,
             MODE_UB, 0, 1, 0, 0, 2'b00, 2'b00);
    add_test("invalid_style", MODE_UB, 0, 3'b000, 4'hF, 9, 4, 5'b00000, 0,
             MODE_UB, 0, 1, 0, 0, 2'b00, 2'b00);
    // In car mode the right motor is bit 1
    add_test("uc_forward", MODE_UC, 0, 3'b001, 4'hF, 100, 100, 5'b10000, 0,
             MODE_UC, 0, 0, 0, 0, 2'b11, 2'b00);
    add_test("uc_backward", MODE_UC, 0, 3'b001, 4'hF, 100, 100, 5'b01000, 0,
             MODE_UC, 0, 0, 0, 0, 2'b00, 2'b11);
    add_test("uc_left", MODE_UC, 0, 3'b001, 4'hF, 100, 100, 5'b00100, 0,
             MODE_UC, 0, 0, 0, 0, 2'b10, 2'b00);
    add_test("uc_right", MODE_UC, 0, 3'b001, 4'hF, 100, 100, 5'b00010, 0,
             MODE_UC, 0, 0, 0, 0, 2'b01, 2'b00);
    add_test("uc_priority", MODE_UC, 0, 3'b001, 4'hF, 100, 100, 5'b11000, 0,
             MODE_UC, 0, 0, 0, 0, 2'b11, 2'b00);
    add_test("uc_ble_err", MODE_UC, 0, 3'b001, 4'hF, 100, 100, 5'b10001, 0,
             MODE_UC, 0, 0, 0, 0, 2'b00, 2'b00);
    add_test("uc_off_target", MODE_UC, 1, 3'b001, 4'hF, 100, 100, 5'b00000, 0,
             MODE_UC, 0, 1, 1, 0, 2'b00, 2'b00);
    add_test("ns_wrap", MODE_NS, 0, 3'b001, 4'hF, 100, 100, 5'b00000, 0,
             MODE_NS, 0, 0, 0, 0, 2'b00, 2'b00);
  endtask

  task automatic drive_row(input int i);
    sw0          = t_sw0[i];
    wanted_ub    = t_wub[i];
    ir_sensor    = t_ir[i];
    distance_0   = t_d0[i];
    distance_1   = t_d1[i];
    ble_forward  = t_cmd[i][4];
    ble_backward = t_cmd[i][3];
    ble_left     = t_cmd[i][2];
    ble_right    = t_cmd[i][1];
    ble_err      = t_cmd[i][0];
  endtask

  task automatic check_value(input string test, input string what, input int exp_val,
                             input int act_val);
    assert (exp_val == act_val) else begin
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", test, what, exp_val, act_val);
      row_errors++;
    end
  endtask

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", cycle_count);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    mode_press   = 1'b0;
    ble_switch   = 1'b0;
    sw0          = 1'b0;
    wanted_ub    = 3'b001;
    ir_sensor    = '1;
    distance_0   = DIST_W'(100);
    distance_1   = DIST_W'(100);
    ble_forward  = 1'b0;
    ble_backward = 1'b0;
    ble_left     = 1'b0;
    ble_right    = 1'b0;
    ble_err      = 1'b0;
    pred_mode    = MODE_NS;
    fill_table();
    // Start once reset has been released
    @(negedge rst);
    @(negedge clk);
    for (int i = 0; i < NUM_TESTS; i++) begin
      // Step the mode until the prediction matches the row
      while (pred_mode != t_mode[i]) begin
        mode_press = 1'b1;
        @(negedge clk);
        mode_press = 1'b0;
        pred_mode  = rotate_mode(pred_mode);
      end
      drive_row(i);
      if (t_pulse[i]) begin
        ble_switch = 1'b1;
        @(negedge clk);
        ble_switch = 1'b0;
      end
      repeat (DEBOUNCE_LEN + 3) @(negedge clk);
      row_errors = 0;
      check_value(t_name[i], "mode", int'(e_mode[i]), int'(mode));
      check_value(t_name[i], "relay", int'(e_relay[i]), int'(relay));
      check_value(t_name[i], "servo_enable", int'(e_en[i]), int'(servo_enable));
      check_value(t_name[i], "servo_sel", int'(e_sel[i]), int'(servo_sel));
      check_value(t_name[i], "servo_amount", int'(e_amt[i]), int'(servo_amount));
      check_value(t_name[i], "motor_cw", int'(e_cw[i]), int'(motor_cw));
      check_value(t_name[i], "motor_ccw", int'(e_ccw[i]), int'(motor_ccw));
      if (row_errors == 0) begin
        pass_count++;
        $display("PASS %s", t_name[i]);
      end else begin
        fail_count++;
        $display("FAIL %s (%0d mismatches)", t_name[i], row_errors);
      end
    end
    $display("Tests run %0d, passed %0d, failed %0d", NUM_TESTS, pass_count, fail_count);
    if (fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== tb_clock_gen.sv ====
/*
 * Testbench clock and reset source.
 * Reset is high from time zero and drops on a falling edge.
 */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst
);

  // Free running clock, low at time zero
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Held through RESET_CYCLES rising edges
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
  end

endmodule

// ==== useless_box_top.sv ====
/*
 * Useless box decision core; all outputs are registered.
 * Strobes are one cycle wide and distances arrive as numbers.
 */
`timescale 1ns/1ps

module useless_box_top
  import useless_box_pkg::*;
#(
  parameter int GOOD_DIS     = 20,
  parameter int SIDE_DELTA   = 4,
  parameter int DEBOUNCE_LEN = 16
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   mode_press,
  input  logic                   ble_switch,
  input  logic                   sw0,
  input  logic [2:0]             wanted_ub,
  input  logic [NUM_IR-1:0]      ir_sensor,
  input  logic [DIST_W-1:0]      distance_0,
  input  logic [DIST_W-1:0]      distance_1,
  input  logic                   ble_forward,
  input  logic                   ble_backward,
  input  logic                   ble_left,
  input  logic                   ble_right,
  input  logic                   ble_err,
  output box_mode_t              mode,
  output logic                   relay,
  output logic                   servo_enable,
  output logic                   servo_sel,
  output logic [SERVO_AMT_W-1:0] servo_amount,
  output logic [1:0]             motor_cw,
  output logic [1:0]             motor_ccw
);

  ub_style_t ub_style;
  logic      switch_off_target;
  logic      object_near;

  box_mode_ctrl u_box_mode_ctrl (
    .clk               (clk),
    .rst               (rst),
    .mode_press        (mode_press),
    .sw0               (sw0),
    .wanted_ub         (wanted_ub),
    .ble_switch        (ble_switch),
    .ble_err           (ble_err),
    .mode              (mode),
    .ub_style          (ub_style),
    .switch_off_target (switch_off_target),
    .relay             (relay)
  );

  ir_debounce #(
    .DEBOUNCE_LEN (DEBOUNCE_LEN)
  ) u_ir_debounce (
    .clk         (clk),
    .rst         (rst),
    .ir_sensor   (ir_sensor),
    .object_near (object_near)
  );

  servo_planner #(
    .GOOD_DIS   (GOOD_DIS),
    .SIDE_DELTA (SIDE_DELTA)
  ) u_servo_planner (
    .clk               (clk),
    .rst               (rst),
    .mode              (mode),
    .ub_style          (ub_style),
    .switch_off_target (switch_off_target),
    .sw0               (sw0),
    .object_near       (object_near),
    .distance_0        (distance_0),
    .distance_1        (distance_1),
    .servo_enable      (servo_enable),
    .servo_sel         (servo_sel),
    .servo_amount      (servo_amount)
  );

  motor_planner #(
    .GOOD_DIS   (GOOD_DIS),
    .SIDE_DELTA (SIDE_DELTA)
  ) u_motor_planner (
    .clk          (clk),
    .rst          (rst),
    .mode         (mode),
    .ub_style     (ub_style),
    .distance_0   (distance_0),
    .distance_1   (distance_1),
    .ble_forward  (ble_forward),
    .ble_backward (ble_backward),
    .ble_left     (ble_left),
    .ble_right    (ble_right),
    .ble_err      (ble_err),
    .motor_cw     (motor_cw),
    .motor_ccw    (motor_ccw)
  );

endmodule

// ==== motor_planner.sv ====
/*
 * Motor drive for dodge and car modes, bit 0 left and bit 1 right.
 * Distance 1 is corrected by SIDE_DELTA before every compare.
 * Car commands are levels; ble_err stops both motors.
 */
`timescale 1ns/1ps

module motor_planner
  import useless_box_pkg::*;
#(
  parameter int GOOD_DIS   = 20,
  parameter int SIDE_DELTA = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  box_mode_t         mode,
  input  ub_style_t         ub_style,
  input  logic [DIST_W-1:0] distance_0,
  input  logic [DIST_W-1:0] distance_1,
  input  logic              ble_forward,
  input  logic              ble_backward,
  input  logic              ble_left,
  input  logic              ble_right,
  input  logic              ble_err,
  output logic [1:0]        motor_cw,
  output logic [1:0]        motor_ccw
);

  localparam int SUM_W = DIST_W + 1;
  // Too close band and too far band for dodging
  localparam logic [SUM_W-1:0] NEAR_LIM = SUM_W'(GOOD_DIS / 3 + 1);
  localparam logic [SUM_W-1:0] FAR_LIM  = SUM_W'(GOOD_DIS / 2);

  logic [SUM_W-1:0] dist0_ext;
  logic [SUM_W-1:0] dist1_adj;
  logic             dodge_stop;
  logic [1:0]       run;
  logic [1:0]       dir;

  assign dist0_ext = SUM_W'(distance_0);
  assign dist1_adj = SUM_W'(distance_1) + SUM_W'(SIDE_DELTA);

  // Already clear of the hand, or no hand at all
  assign dodge_stop = (dist0_ext < NEAR_LIM) || (dist1_adj < NEAR_LIM) ||
                      ((dist0_ext > FAR_LIM) && (dist1_adj > FAR_LIM));

  always_comb begin
    run = 2'b00;
    dir = 2'b00;
    if (mode == MODE_UB && ub_style == STYLE_DODGE && !dodge_stop) begin
      run = 2'b11;
      // Hand nearer the right side drives in reverse
      dir = (dist0_ext > dist1_adj) ? 2'b00 : 2'b11;
    end else if (mode == MODE_UC && !ble_err) begin
      if (ble_forward) begin
        run = 2'b11;
        dir = 2'b11;
      end else if (ble_backward) begin
        run = 2'b11;
        dir = 2'b00;
      end else if (ble_left) begin
        // Right wheel only
        run = 2'b10;
        dir = 2'b10;
      end else if (ble_right) begin
        run = 2'b01;
        dir = 2'b01;
      end
    end
  end

  // Split enable and direction onto the two driver lines
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      motor_cw  <= 2'b00;
      motor_ccw <= 2'b00;
    end else begin
      motor_cw  <= run & dir;
      motor_ccw <= run & ~dir;
    end
  end

  a_no_shoot_through: assert property (@(posedge clk) disable iff (rst)
    (motor_cw & motor_ccw) == 2'b00)
    else $error("motor cw and ccw both high, cw=%b ccw=%b", motor_cw, motor_ccw);

endmodule

// ==== servo_planner.sv ====
/*
 * Chooses servo enable, side and lift amount each cycle.
 * Distance 1 is corrected by SIDE_DELTA for the asymmetric box.
 * Outputs are registered one cycle after their inputs.
 */
`timescale 1ns/1ps

module servo_planner
  import useless_box_pkg::*;
#(
  parameter int GOOD_DIS   = 20,
  parameter int SIDE_DELTA = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  box_mode_t              mode,
  input  ub_style_t              ub_style,
  input  logic                   switch_off_target,
  input  logic                   sw0,
  input  logic                   object_near,
  input  logic [DIST_W-1:0]      distance_0,
  input  logic [DIST_W-1:0]      distance_1,
  output logic                   servo_enable,
  output logic                   servo_sel,
  output logic [SERVO_AMT_W-1:0] servo_amount
);

  // One spare bit for the side correction, two more for the scale
  localparam int SUM_W = DIST_W + 1;
  localparam logic [SUM_W-1:0]   GOOD_LIM = SUM_W'(GOOD_DIS);
  localparam logic [SUM_W+1:0]   CAP_LIM  = (SUM_W + 2)'(SERVO_AMT_CAP);

  logic [SUM_W-1:0]       dist0_ext;
  logic [SUM_W-1:0]       dist1_adj;
  logic [SUM_W-1:0]       near_dist;
  logic [SUM_W+1:0]       scaled;
  logic [SERVO_AMT_W-1:0] closer_amt;
  logic                   en_d;
  logic                   sel_d;
  logic [SERVO_AMT_W-1:0] amt_d;

  assign dist0_ext = SUM_W'(distance_0);
  assign dist1_adj = SUM_W'(distance_1) + SUM_W'(SIDE_DELTA);
  assign near_dist = (dist0_ext > dist1_adj) ? dist1_adj : dist0_ext;
  assign scaled    = near_dist * (SUM_W + 2)'(CLOSER_SCALE);

  // Closer effect, arm rises as the hand approaches
  always_comb begin
    if (object_near) begin
      closer_amt = SERVO_AMT_MAX;
    end else if (dist0_ext > GOOD_LIM && dist1_adj > GOOD_LIM) begin
      // Nobody around
      closer_amt = '0;
    end else if (scaled < CAP_LIM) begin
      closer_amt = scaled[SERVO_AMT_W-1:0];
    end else begin
      closer_amt = SERVO_AMT_MAX;
    end
  end

  always_comb begin
    en_d  = 1'b0;
    sel_d = sw0;
    amt_d = '0;
    if (switch_off_target) begin
      en_d = 1'b1;
      // Push back from the far side, dodge and UC leave it
      if (mode == MODE_NS ||
          (mode == MODE_UB &&
           (ub_style == STYLE_CLASSIC || ub_style == STYLE_ADVANCE))) begin
        sel_d = ~sw0;
        amt_d = SERVO_AMT_MAX;
      end
    end else if (mode == MODE_UB) begin
      en_d = 1'b1;
      if (ub_style == STYLE_ADVANCE) begin
        sel_d = ~sw0;
        amt_d = closer_amt;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      servo_enable <= 1'b0;
      servo_sel    <= 1'b0;
      servo_amount <= '0;
    end else begin
      servo_enable <= en_d;
      servo_sel    <= sel_d;
      servo_amount <= amt_d;
    end
  end

  a_amt_needs_en: assert property (@(posedge clk) disable iff (rst)
    (servo_amount != '0) |-> servo_enable)
    else $error("servo amount %0d while disabled", servo_amount);

endmodule

// ==== box_mode_ctrl.sv ====
/*
 * Mode FSM, wanted switch position, style decode and relay.
 * mode_press and ble_switch must be single-cycle strobes.
 * The wanted position loads sw0 on the first edge after reset.
 */
`timescale 1ns/1ps

module box_mode_ctrl
  import useless_box_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       mode_press,
  input  logic       sw0,
  input  logic [2:0] wanted_ub,
  input  logic       ble_switch,
  input  logic       ble_err,
  output box_mode_t  mode,
  output ub_style_t  ub_style,
  output logic       switch_off_target,
  output logic       relay
);

  box_mode_t mode_next;
  logic      target_init;
  logic      sw_target;

  // Rotation NS -> UB -> UC -> NS
  always_comb begin
    unique case (mode)
      MODE_NS: mode_next = MODE_UB;
      MODE_UB: mode_next = MODE_UC;
      default: mode_next = MODE_NS;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mode <= MODE_NS;
    end else if (mode_press) begin
      mode <= mode_next;
    end
  end

  // High for the first edge after reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      target_init <= 1'b1;
    end else begin
      target_init <= 1'b0;
    end
  end

  // Wanted position, remote toggle only honoured in NS mode
  always_ff @(posedge clk) begin
    if (target_init) begin
      sw_target <= sw0;
    end else if (mode == MODE_NS && ble_switch && !ble_err) begin
      sw_target <= ~sw_target;
    end
  end

  // Mismatch flag and relay for the planners and the load
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      switch_off_target <= 1'b0;
      relay             <= 1'b0;
    end else begin
      switch_off_target <= !target_init && (sw0 != sw_target);
      // Load powered only as a plain switch
      relay             <= (mode == MODE_NS) ? sw0 : 1'b0;
    end
  end

  // One-hot request, zero or several bits is invalid
  always_comb begin
    case (wanted_ub)
      3'b001:  ub_style = STYLE_CLASSIC;
      3'b010:  ub_style = STYLE_DODGE;
      3'b100:  ub_style = STYLE_ADVANCE;
      default: ub_style = STYLE_INVALID;
    endcase
  end

  a_mode_legal: assert property (@(posedge clk) disable iff (rst)
    mode inside {MODE_NS, MODE_UB, MODE_UC})
    else $error("illegal mode code %b", mode);

  a_target_ns_only: assert property (@(posedge clk) disable iff (rst)
    (!target_init && mode != MODE_NS) |=> $stable(sw_target))
    else $error("wanted switch position moved outside NS mode");

endmodule

// ==== ir_debounce.sv ====
/*
 * IR inputs are active low; any low sensor means an object is near.
 * The flag changes only after DEBOUNCE_LEN equal samples in a row.
 */
`timescale 1ns/1ps

module ir_debounce #(
  parameter int DEBOUNCE_LEN = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [3:0] ir_sensor,
  output logic       object_near
);

  localparam int CNT_W = (DEBOUNCE_LEN > 1) ? $clog2(DEBOUNCE_LEN) : 1;

  logic             raw_near;
  logic [CNT_W-1:0] stable_cnt;

  // Any sensor pulled low sees something
  assign raw_near = ~&ir_sensor;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stable_cnt  <= '0;
      object_near <= 1'b0;
    end else if (raw_near == object_near) begin
      // Agrees with the flag, restart the run
      stable_cnt <= '0;
    end else if (stable_cnt == CNT_W'(DEBOUNCE_LEN - 1)) begin
      // Held long enough, take the new level
      stable_cnt  <= '0;
      object_near <= raw_near;
    end else begin
      stable_cnt <= stable_cnt + 1'b1;
    end
  end

endmodule

// ==== useless_box_pkg.sv ====
/*
 * Mode and style types plus fixed widths for the useless box core.
 * Mode codes match the board encoding (NS 0, UB 2, UC 3).
 * Servo amounts are 5 bits wide, so 31 is the full push.
 */
package useless_box_pkg;

  // Operating mode of the box
  typedef enum logic [1:0] {
    MODE_NS = 2'b00,
    MODE_UB = 2'b10,
    MODE_UC = 2'b11
  } box_mode_t;

  // Useless-box style after decode of the one-hot request
  typedef enum logic [1:0] {
    STYLE_CLASSIC = 2'd0,
    STYLE_DODGE   = 2'd1,
    STYLE_ADVANCE = 2'd2,
    STYLE_INVALID = 2'd3
  } ub_style_t;

  // Distance reading width, in sensor units
  localparam int DIST_W = 20;

  // Servo lift amount
  localparam int SERVO_AMT_W = 5;
  localparam logic [SERVO_AMT_W-1:0] SERVO_AMT_MAX = 5'd31;

  // Scaled distances at or above this push fully
  localparam int SERVO_AMT_CAP = 25;

  // Closer effect gain on the corrected distance
  localparam int CLOSER_SCALE = 3;

  // IR proximity sensors around the switch
  localparam int NUM_IR = 4;

endpackage
